// ==== mult_array.f ====
+incdir+.
mult_pkg.sv
table_control.sv
mult_lane.sv
result_reader.sv
mult_unit.sv
mult_array_top.sv
tb_mult_array.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator and run the testbench from the project root.

LOG=sim.log

verilator --binary --timing -f mult_array.f --top-module tb_mult_array -o tb_mult_array
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_mult_array > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
    exit 0
fi
exit 1

// ==== tb_mult_array.sv ====
`include "mult_defines.svh"

module tb_mult_array;
    import mult_pkg::*;

    localparam int DEPTH           = `TABLE_DEPTH;
    localparam int N_PASSES        = 4;
    localparam int WATCHDOG_CYCLES = N_PASSES * (DEPTH + 4) + 200;

    logic               clk;
    logic               rst_n;
    ucmd_t              command;
    tcmd_t              tcmd;
    word_t              tdatai;
    taddr_t             twraddr;
    logic               twren;
    logic [`USEL_W-1:0] unit_select;
    laddr_t             g_addr;
    word_t              g_data;
    logic               g_rden;
    logic               g_wren;
    word_t              g_q;
    logic               idle;
    logic               t_idle;

    word_t       tcol [3][DEPTH];    // mirror of the coefficient table.
    word_t       x_model [`LANES];
    word_t       acc_model [`LANES];
    word_t       last_q = '0;        // what g_q should hold between reads.
    word_t       exp_q [$];
    int          errors = 0;
    int          checks = 0;
    int          idle_runs = 0;
    int unsigned seed;

    mult_array_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .command     (command),
        .tcmd        (tcmd),
        .tdatai      (tdatai),
        .twraddr     (twraddr),
        .twren       (twren),
        .unit_select (unit_select),
        .g_addr      (g_addr),
        .g_data      (g_data),
        .g_rden      (g_rden),
        .g_wren      (g_wren),
        .g_q         (g_q),
        .idle        (idle),
        .t_idle      (t_idle)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // one full pass over a column modulo 2**WORD_W.
    function automatic word_t horner_ref(word_t prev, word_t x, word_t coefs [DEPTH]);
        word_t acc;
        acc = prev;
        for (int i = 0; i < DEPTH; i++)
            acc = acc * x + coefs[i];
        return acc;
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic write_table(input taddr_t addr, input word_t data);
        @(posedge clk);
        tdatai  <= data;
        twraddr <= addr;
        twren   <= 1'b1;
        @(posedge clk);
        twren   <= 1'b0;
        tcol[0][addr] = data;
        tcol[1][addr] = data + word_t'(1);
        tcol[2][addr] = data + word_t'(2);
    endtask

    task automatic write_x(input laddr_t lane, input word_t data, input logic [`USEL_W-1:0] sel);
        @(posedge clk);
        unit_select <= sel;
        g_addr      <= lane;
        g_data      <= data;
        g_wren      <= 1'b1;
        @(posedge clk);
        g_wren      <= 1'b0;
        unit_select <= '0;
        if (sel == '0)
            x_model[lane] = data;
    endtask

    task automatic read_lane(input laddr_t lane, input logic [`USEL_W-1:0] sel);
        @(posedge clk);
        unit_select <= sel;
        g_addr      <= lane;
        g_rden      <= 1'b1;
        if (sel == '0)
            last_q = acc_model[lane];
        exp_q.push_back(last_q);
        @(posedge clk);
        g_rden      <= 1'b0;
        unit_select <= '0;
    endtask

    task automatic read_all(input logic [`USEL_W-1:0] sel);
        for (int i = 0; i < `LANES; i++)
            read_lane(laddr_t'(i), sel);
    endtask

    task automatic clear_all();
        @(posedge clk);
        command <= `CMD_CLEAR;
        @(posedge clk);
        command <= `CMD_NOP;
        for (int i = 0; i < `LANES; i++)
            acc_model[i] = '0;
    endtask

    // table and unit start on the same edge; busy_cmd lands mid-pass.
    task automatic run_pass(input ucmd_t cmd, input int col, input logic busy_cmd);
        word_t coefs [DEPTH];
        for (int i = 0; i < DEPTH; i++)
            coefs[i] = tcol[col][i];
        @(posedge clk);
        command <= cmd;
        tcmd    <= `TCMD_START;
        @(posedge clk);
        command <= `CMD_NOP;
        tcmd    <= `TCMD_NOP;
        for (int i = 0; i < `LANES; i++)
            acc_model[i] = horner_ref(acc_model[i], x_model[i], coefs);
        do @(negedge clk); while (idle);
        check("t_idle", word_t'(t_idle), word_t'(1'b0)); // table streams alongside the unit.
        if (busy_cmd) begin
            @(posedge clk);
            command <= `CMD_EVAL2;
            @(posedge clk);
            command <= `CMD_NOP;
        end
        do @(negedge clk); while (!idle);
        check("t_idle", word_t'(t_idle), word_t'(1'b1));
    endtask

    // read-back comparison and idle run length sampled mid-cycle.
    initial begin
        int   low_cnt;
        logic pending;
        low_cnt = 0;
        pending = 1'b0;
        forever begin
            @(negedge clk);
            if (pending)
                check("g_q", g_q, exp_q.pop_front());
            pending = g_rden;
            if (!idle) begin
                low_cnt++;
            end else if (low_cnt != 0) begin
                idle_runs++;
                check("idle_low_cycles", word_t'(low_cnt), word_t'(DEPTH + 1));
                low_cnt = 0;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        seed = $urandom(32'h95eb);
        rst_n       <= 1'b0;
        command     <= `CMD_NOP;
        tcmd        <= `TCMD_NOP;
        tdatai      <= '0;
        twraddr     <= '0;
        twren       <= 1'b0;
        unit_select <= '0;
        g_addr      <= '0;
        g_data      <= '0;
        g_rden      <= 1'b0;
        g_wren      <= 1'b0;
        for (int i = 0; i < `LANES; i++) begin
            x_model[i]   = '0;
            acc_model[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check("idle", word_t'(idle), word_t'(1'b1));
        check("t_idle", word_t'(t_idle), word_t'(1'b1));
        read_all('0);

        for (int i = 0; i < DEPTH; i++)
            write_table(taddr_t'(i), word_t'($urandom()));
        for (int i = 0; i < `LANES; i++)
            write_x(laddr_t'(i), word_t'($urandom()), '0);
        clear_all();
        run_pass(`CMD_EVAL0, 0, 1'b0);
        read_all('0);

        // chained passes where the last one gets a command while busy.
        run_pass(`CMD_EVAL1, 1, 1'b0);
        read_all('0);
        run_pass(`CMD_EVAL2, 2, 1'b1);
        read_all('0);

        clear_all();
        read_all('0);

        // nothing should move under another unit select.
        for (int i = 0; i < `LANES; i++)
            write_x(laddr_t'(i), word_t'($urandom()), `USEL_W'(3));
        run_pass(`CMD_EVAL0, 0, 1'b0);
        read_all('0);
        read_all(`USEL_W'(3));

        while (exp_q.size() != 0)
            @(negedge clk);
        @(negedge clk);
        check("idle_runs", word_t'(idle_runs), word_t'(N_PASSES));
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== mult_array_top.sv ====
`include "mult_defines.svh"

module mult_array_top (
    input  logic                clk,
    input  logic                rst_n,
    input  mult_pkg::ucmd_t      command,
    input  mult_pkg::tcmd_t      tcmd,
    input  mult_pkg::word_t      tdatai,
    input  mult_pkg::taddr_t     twraddr,
    input  logic                twren,
    input  logic [`USEL_W-1:0]  unit_select,
    input  mult_pkg::laddr_t     g_addr,
    input  mult_pkg::word_t      g_data,
    input  logic                g_rden,
    input  logic                g_wren,
    output mult_pkg::word_t      g_q,
    output logic                idle,
    output logic                t_idle
);
    import mult_pkg::*;

    word_t tdata_0;
    word_t tdata_1;
    word_t tdata_2;

    table_control u_table (
        .clk     (clk),
        .rst_n   (rst_n),
        .tdatai  (tdatai),
        .twraddr (twraddr),
        .twren   (twren),
        .command (tcmd),
        .tdata_0 (tdata_0),
        .tdata_1 (tdata_1),
        .tdata_2 (tdata_2),
        .idle    (t_idle)
    );

    mult_unit #(
        .mult_addr (0)
    ) u_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .unit_select (unit_select),
        .g_addr      (g_addr),
        .g_data      (g_data),
        .g_rden      (g_rden),
        .g_wren      (g_wren),
        .command     (command),
        .tdata_0     (tdata_0),
        .tdata_1     (tdata_1),
        .tdata_2     (tdata_2),
        .g_q         (g_q),
        .idle        (idle)
    );

endmodule

// ==== mult_unit.sv ====
`include "mult_defines.svh"

module mult_unit #(
    parameter int unsigned mult_addr = 0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`USEL_W-1:0]  unit_select,
    input  mult_pkg::laddr_t     g_addr,
    input  mult_pkg::word_t      g_data,
    input  logic                g_rden,
    input  logic                g_wren,
    input  mult_pkg::ucmd_t      command,
    input  mult_pkg::word_t      tdata_0,
    input  mult_pkg::word_t      tdata_1,
    input  mult_pkg::word_t      tdata_2,
    output mult_pkg::word_t      g_q,
    output logic                idle
);
    import mult_pkg::*;

    unit_state_t            state;
    taddr_t                 cnt;
    logic                   step;
    logic [1:0]             col_sel;
    logic                   accept;
    logic                   is_eval;
    logic                   clear;
    logic                   sel_hit;
    word_t                  coef;
    word_t [`LANES-1:0]     lane_acc;

    assign accept  = idle && (state == ST_IDLE);
    assign is_eval = (command == `CMD_EVAL0) || (command == `CMD_EVAL1) ||
                     (command == `CMD_EVAL2);
    assign clear   = accept && (command == `CMD_CLEAR);
    assign sel_hit = (unit_select == `USEL_W'(mult_addr));

    // column picked at the start of the pass.
    always_comb begin
        case (col_sel)
            2'd1:    coef = tdata_1;
            2'd2:    coef = tdata_2;
            default: coef = tdata_0;
        endcase
    end

    // one wait cycle to line up with the table register, then DEPTH steps.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            cnt     <= '0;
            step    <= 1'b0;
            col_sel <= 2'd0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept && is_eval) begin
                        state <= ST_EVAL;
                        cnt   <= '0;
                        case (command)
                            `CMD_EVAL1: col_sel <= 2'd1;
                            `CMD_EVAL2: col_sel <= 2'd2;
                            default:    col_sel <= 2'd0;
                        endcase
                    end
                end
                ST_EVAL: begin
                    if (!step) begin
                        step <= 1'b1;
                    end else begin
                        cnt <= cnt + taddr_t'(1);
                        if (cnt == taddr_t'(`TABLE_DEPTH - 1)) begin
                            step  <= 1'b0;
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            idle <= 1'b1;
        else
            idle <= (state == ST_IDLE); // one cycle behind the state.
    end

    for (genvar i = 0; i < `LANES; i++) begin : g_lane
        mult_lane u_lane (
            .clk    (clk),
            .rst_n  (rst_n),
            .x_wren (g_wren && sel_hit && (g_addr == laddr_t'(i))),
            .x_data (g_data),
            .clear  (clear),
            .step   (step),
            .coef   (coef),
            .acc    (lane_acc[i])
        );
    end

    result_reader u_reader (
        .clk      (clk),
        .rst_n    (rst_n),
        .rden     (g_rden && sel_hit),
        .addr     (g_addr),
        .lane_acc (lane_acc),
        .q        (g_q)
    );

endmodule

// ==== result_reader.sv ====
`include "mult_defines.svh"

module result_reader (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           rden,
    input  mult_pkg::laddr_t                addr,
    input  mult_pkg::word_t [`LANES-1:0]    lane_acc,
    output mult_pkg::word_t                 q
);

    // q only moves on a read, so the host sees a stable value in between.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            q <= '0;
        else if (rden)
            q <= lane_acc[addr];
    end

endmodule

// ==== mult_lane.sv ====
`include "mult_defines.svh"

module mult_lane (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           x_wren,
    input  mult_pkg::word_t x_data,
    input  logic           clear,
    input  logic           step,
    input  mult_pkg::word_t coef,
    output mult_pkg::word_t acc
);
    import mult_pkg::*;

    word_t                  x;
    word_t                  prod;
    word_t                  acc_next;

    // horner step truncated to one word.
    assign prod     = acc * x;
    assign acc_next = prod + coef;

    // operand register written from the host bus.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            x <= '0;
        else if (x_wren)
            x <= x_data;
    end

    // accumulator.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (step) begin
            acc <= acc_next;
        end
    end

endmodule

// ==== table_control.sv ====
`include "mult_defines.svh"

module table_control (
    input  logic            clk,
    input  logic            rst_n,
    input  mult_pkg::word_t  tdatai,
    input  mult_pkg::taddr_t twraddr,
    input  logic            twren,
    input  mult_pkg::tcmd_t  command,
    output mult_pkg::word_t  tdata_0,
    output mult_pkg::word_t  tdata_1,
    output mult_pkg::word_t  tdata_2,
    output logic            idle
);
    import mult_pkg::*;

    word_t  col_0 [`TABLE_DEPTH];
    word_t  col_1 [`TABLE_DEPTH];
    word_t  col_2 [`TABLE_DEPTH];
    taddr_t rd_addr;
    logic   active;
    logic   start;

    // a start is taken only once the previous stream has fully drained.
    assign start = (command == `TCMD_START) && idle && !active;

    // host write port, one column-triple per cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `TABLE_DEPTH; i++) begin
                col_0[i] <= '0;
                col_1[i] <= '0;
                col_2[i] <= '0;
            end
        end else if (twren) begin
            col_0[twraddr] <= tdatai;
            col_1[twraddr] <= tdatai + word_t'(1);
            col_2[twraddr] <= tdatai + word_t'(2);
        end
    end

    // stream address counter.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            rd_addr <= '0;
        end else if (start) begin
            active  <= 1'b1;
            rd_addr <= '0;
        end else if (active) begin
            rd_addr <= rd_addr + taddr_t'(1);
            if (rd_addr == taddr_t'(`TABLE_DEPTH - 1))
                active <= 1'b0; // last entry goes out on this edge.
        end
    end

    // registered outputs.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tdata_0 <= '0;
            tdata_1 <= '0;
            tdata_2 <= '0;
        end else if (active) begin
            tdata_0 <= col_0[rd_addr];
            tdata_1 <= col_1[rd_addr];
            tdata_2 <= col_2[rd_addr];
        end
    end

    // idle trails the counter by one cycle, so it covers every presented entry.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            idle <= 1'b1;
        else
            idle <= !active;
    end

endmodule

// ==== mult_pkg.sv ====
`include "mult_defines.svh"

package mult_pkg;

    // one coefficient or accumulator word.
    typedef logic [`WORD_W-1:0] word_t;

    // table entry and lane addresses.
    typedef logic [`TADDR_W-1:0] taddr_t;
    typedef logic [`LADDR_W-1:0] laddr_t;

    // command words.
    typedef logic [2:0] ucmd_t;
    typedef logic [1:0] tcmd_t;

    // unit sequencer.
    typedef enum logic {
        ST_IDLE,
        ST_EVAL
    } unit_state_t;

endpackage

// ==== mult_defines.svh ====
`ifndef MULT_DEFINES_SVH
`define MULT_DEFINES_SVH

// data path sizes.
`define WORD_W      27
`define LANES       4
`define TABLE_DEPTH 8
`define TADDR_W     3
`define LADDR_W     2
`define USEL_W      4   // width of the unit select on the host bus.

// unit commands.
`define CMD_NOP     3'b000
`define CMD_CLEAR   3'b100
`define CMD_EVAL0   3'b010
`define CMD_EVAL1   3'b011
`define CMD_EVAL2   3'b101

// table commands.
`define TCMD_NOP    2'b00
`define TCMD_START  2'b01

`endif
